// ==== verilog.f ====
logic/rv_decode_pkg.sv
logic/cir_if.sv
logic/dec_if.sv
logic/fetch_queue.sv
logic/instr_decoder.sv
logic/decode_ctrl.sv
logic/rv_decode_stage.sv
verification/rv_decode_asserts.sv
verification/tb_rv_decode_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_rv_decode_stage \
	-f verilog.f \
	-Mdir obj_dir

./obj_dir/Vtb_rv_decode_stage 2>&1 | tee "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
	echo "Simulation reported a failure, see $LOG"
	exit 1
fi

if ! grep -q "ALL TESTS PASSED" "$LOG"; then
	echo "Simulation ended without a pass line, see $LOG"
	exit 1
fi

echo "Simulation passed"

// ==== verification/tb_rv_decode_stage.sv ====
`timescale 1ns/1ps

module tb_rv_decode_stage;
	import rv_decode_pkg::*;

	localparam word_t RESET_VECTOR = '0;
	localparam int    CIR_DEPTH    = 2;
	localparam real   PERIOD       = 4.0;

	// Cycle budget of each test with reset counted in the first
	localparam int T_RESET = 10;
	localparam int T_ALU   = 30;
	localparam int T_MEM   = 60;
	localparam int T_EXC   = 12;
	localparam int T_FLOW  = 40;
	localparam int T_JUMP  = 15;
	localparam real TIMEOUT = (T_RESET + T_ALU + T_MEM + T_EXC + T_FLOW + T_JUMP) * PERIOD * 2;

	logic      clk;
	logic      rst_n;
	logic      fetch_vld_i;
	word_t     fetch_instr_i;
	logic      fetch_err_i;
	logic      fetch_ready_o;
	logic      x_stall_i;
	logic      jump_now_i;
	word_t     jump_target_i;
	word_t     d_pc_o;
	logic      d_starved_o;
	except_e   d_except_o;
	regaddr_t  d_rs1_o;
	regaddr_t  d_rs2_o;
	regaddr_t  d_rd_o;
	word_t     d_imm_o;
	word_t     d_addr_offs_o;
	aluop_e    d_aluop_o;
	alusrc_a_e d_alusrc_a_o;
	alusrc_b_e d_alusrc_b_o;
	memop_e    d_memop_o;
	bcond_e    d_branchcond_o;
	logic      d_addr_is_regoffs_o;

	// Expected decode of the word at the head
	regaddr_t  e_rs1;
	regaddr_t  e_rs2;
	regaddr_t  e_rd;
	word_t     e_imm;
	word_t     e_offs;
	aluop_e    e_aluop;
	alusrc_a_e e_srca;
	alusrc_b_e e_srcb;
	memop_e    e_memop;
	bcond_e    e_bcond;
	logic      e_regoffs;
	except_e   e_except;
	word_t     exp_pc;
	integer    seed;

	rv_decode_stage DUT (
		.clk                 (clk),
		.rst_n               (rst_n),
		.fetch_vld_i         (fetch_vld_i),
		.fetch_instr_i       (fetch_instr_i),
		.fetch_err_i         (fetch_err_i),
		.fetch_ready_o       (fetch_ready_o),
		.x_stall_i           (x_stall_i),
		.jump_now_i          (jump_now_i),
		.jump_target_i       (jump_target_i),
		.d_pc_o              (d_pc_o),
		.d_starved_o         (d_starved_o),
		.d_except_o          (d_except_o),
		.d_rs1_o             (d_rs1_o),
		.d_rs2_o             (d_rs2_o),
		.d_rd_o              (d_rd_o),
		.d_imm_o             (d_imm_o),
		.d_addr_offs_o       (d_addr_offs_o),
		.d_aluop_o           (d_aluop_o),
		.d_alusrc_a_o        (d_alusrc_a_o),
		.d_alusrc_b_o        (d_alusrc_b_o),
		.d_memop_o           (d_memop_o),
		.d_branchcond_o      (d_branchcond_o),
		.d_addr_is_regoffs_o (d_addr_is_regoffs_o)
	);

	always #(PERIOD / 2) clk = ~clk;

	// -------------------------------------------------------------------
	// Run control and compare tasks

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t want);
		if (got !== want)
			abort_run($sformatf("** Error at %0t: %s is %h, expected %h",
				$realtime, name, got, want));
	endtask

	task automatic check_reg(input string name, input regaddr_t got, input regaddr_t want);
		if (got !== want)
			abort_run($sformatf("** Error at %0t: %s is %0d, expected %0d",
				$realtime, name, got, want));
	endtask

	task automatic check_aluop(input string name, input aluop_e got, input aluop_e want);
		if (got !== want)
			abort_run($sformatf("** Error at %0t: %s is %s, expected %s",
				$realtime, name, got.name(), want.name()));
	endtask

	task automatic check_memop(input string name, input memop_e got, input memop_e want);
		if (got !== want)
			abort_run($sformatf("** Error at %0t: %s is %s, expected %s",
				$realtime, name, got.name(), want.name()));
	endtask

	task automatic check_bcond(input string name, input bcond_e got, input bcond_e want);
		if (got !== want)
			abort_run($sformatf("** Error at %0t: %s is %s, expected %s",
				$realtime, name, got.name(), want.name()));
	endtask

	task automatic check_except(input string name, input except_e got, input except_e want);
		if (got !== want)
			abort_run($sformatf("** Error at %0t: %s is %s, expected %s",
				$realtime, name, got.name(), want.name()));
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want)
			abort_run($sformatf("** Error at %0t: %s is %b, expected %b",
				$realtime, name, got, want));
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#0.5;
	endtask

	task automatic rand_word(output word_t r);
		r = $random(seed);
	endtask

	// -------------------------------------------------------------------
	// Instruction encoders

	function automatic word_t enc_r(input logic [6:0] f7, input regaddr_t rs2,
			input regaddr_t rs1, input logic [2:0] f3, input regaddr_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP, 2'b11};
	endfunction

	function automatic word_t enc_i(input logic [11:0] imm, input regaddr_t rs1,
			input logic [2:0] f3, input regaddr_t rd, input opcode_e opc);
		return {imm, rs1, f3, rd, opc, 2'b11};
	endfunction

	function automatic word_t enc_s(input logic [11:0] imm, input regaddr_t rs2,
			input regaddr_t rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE, 2'b11};
	endfunction

	function automatic word_t enc_b(input logic [12:0] imm, input regaddr_t rs2,
			input regaddr_t rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH, 2'b11};
	endfunction

	function automatic word_t enc_u(input logic [19:0] imm, input regaddr_t rd,
			input opcode_e opc);
		return {imm, rd, opc, 2'b11};
	endfunction

	function automatic word_t enc_j(input logic [20:0] imm, input regaddr_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL, 2'b11};
	endfunction

	// -------------------------------------------------------------------
	// Reference decode of one word at a valid head

	task automatic ref_decode(input word_t w, input logic err);
		logic [4:0] opc;
		logic [2:0] f3;
		logic [6:0] f7;
		logic       ill;
		aluop_e     alu_tbl [8];
		opc = w[6:2];
		f3  = w[14:12];
		f7  = w[31:25];
		alu_tbl = '{ALUOP_ADD, ALUOP_SLL, ALUOP_LT, ALUOP_LTU,
			ALUOP_XOR, ALUOP_SRL, ALUOP_OR, ALUOP_AND};
		e_rs1     = w[19:15];
		e_rs2     = w[24:20];
		e_rd      = w[11:7];
		e_imm     = {{20{w[31]}}, w[31:20]};
		e_offs    = '0;
		e_aluop   = ALUOP_ADD;
		e_srca    = ALUSRCA_RS1;
		e_srcb    = ALUSRCB_RS2;
		e_memop   = MEMOP_NONE;
		e_bcond   = BCOND_NEVER;
		e_regoffs = 1'b0;
		ill       = w[1:0] != 2'b11;
		case (opc)
			5'b00100, 5'b01100: begin
				e_aluop = alu_tbl[f3];
				if (opc == 5'b00100) begin
					e_rs2  = '0;
					e_srcb = ALUSRCB_IMM;
					ill = ill || (f3 == 3'd1 && f7 != 7'h00);
					ill = ill || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
				end else begin
					ill = ill || (f7 != 7'h00 && f7 != 7'h20);
					ill = ill || (f7 == 7'h20 && f3 != 3'd0 && f3 != 3'd5);
					if (w[30] && f3 == 3'd0)
						e_aluop = ALUOP_SUB;
				end
				if (w[30] && f3 == 3'd5)
					e_aluop = ALUOP_SRA;
			end
			5'b01101, 5'b00101: begin
				e_rs1  = '0;
				e_rs2  = '0;
				e_imm  = {w[31:12], 12'h000};
				e_srcb = ALUSRCB_IMM;
				if (opc == 5'b01101)
					e_aluop = ALUOP_RS2;
				else
					e_srca = ALUSRCA_PC;
			end
			5'b00000: begin
				e_rs2     = '0;
				e_regoffs = 1'b1;
				e_offs    = {{20{w[31]}}, w[31:20]};
				case (f3)
					3'd0:    e_memop = MEMOP_LB;
					3'd1:    e_memop = MEMOP_LH;
					3'd2:    e_memop = MEMOP_LW;
					3'd4:    e_memop = MEMOP_LBU;
					3'd5:    e_memop = MEMOP_LHU;
					default: ill = 1'b1;
				endcase
			end
			5'b01000: begin
				e_rd      = '0;
				e_aluop   = ALUOP_RS2;
				e_regoffs = 1'b1;
				e_offs    = {{20{w[31]}}, w[31:25], w[11:7]};
				case (f3)
					3'd0:    e_memop = MEMOP_SB;
					3'd1:    e_memop = MEMOP_SH;
					3'd2:    e_memop = MEMOP_SW;
					default: ill = 1'b1;
				endcase
			end
			5'b11000: begin
				e_rd   = '0;
				e_offs = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
				// BLT/BGE and the unsigned pair test the compare flag
				case (f3)
					3'd0: begin
						e_aluop = ALUOP_SUB;
						e_bcond = BCOND_ZERO;
					end
					3'd1: begin
						e_aluop = ALUOP_SUB;
						e_bcond = BCOND_NZERO;
					end
					3'd4: begin
						e_aluop = ALUOP_LT;
						e_bcond = BCOND_NZERO;
					end
					3'd5: begin
						e_aluop = ALUOP_LT;
						e_bcond = BCOND_ZERO;
					end
					3'd6: begin
						e_aluop = ALUOP_LTU;
						e_bcond = BCOND_NZERO;
					end
					3'd7: begin
						e_aluop = ALUOP_LTU;
						e_bcond = BCOND_ZERO;
					end
					default: ill = 1'b1;
				endcase
			end
			5'b11011, 5'b11001: begin
				e_rs2   = '0;
				e_imm   = 32'd4;
				e_srca  = ALUSRCA_PC;
				e_srcb  = ALUSRCB_IMM;
				e_bcond = BCOND_ALWAYS;
				if (opc == 5'b11011) begin
					e_rs1  = '0;
					e_offs = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
				end else begin
					e_regoffs = 1'b1;
					e_offs    = {{20{w[31]}}, w[31:20]};
					ill       = ill || f3 != 3'd0;
				end
			end
			5'b00011: begin
				e_rs2 = '0;
				ill   = ill || f3 != 3'd0;
			end
			default: ill = 1'b1;
		endcase
		if (err || ill) begin
			e_rs1   = '0;
			e_rs2   = '0;
			e_rd    = '0;
			e_memop = MEMOP_NONE;
			e_bcond = BCOND_NEVER;
		end
		e_except = err ? EXCEPT_INSTR_FAULT : (ill ? EXCEPT_INSTR_ILLEGAL : EXCEPT_NONE);
	endtask

	// -------------------------------------------------------------------
	// Stimulus and response helpers

	task automatic compare_decoded(input word_t w, input logic err);
		ref_decode(w, err);
		check_word("d_pc_o", d_pc_o, exp_pc);
		check_bit("d_starved_o", d_starved_o, 1'b0);
		check_reg("d_rs1_o", d_rs1_o, e_rs1);
		check_reg("d_rs2_o", d_rs2_o, e_rs2);
		check_reg("d_rd_o", d_rd_o, e_rd);
		check_word("d_imm_o", d_imm_o, e_imm);
		check_word("d_addr_offs_o", d_addr_offs_o, e_offs);
		check_aluop("d_aluop_o", d_aluop_o, e_aluop);
		check_bit("d_alusrc_a_o", d_alusrc_a_o, e_srca);
		check_bit("d_alusrc_b_o", d_alusrc_b_o, e_srcb);
		check_memop("d_memop_o", d_memop_o, e_memop);
		check_bcond("d_branchcond_o", d_branchcond_o, e_bcond);
		check_bit("d_addr_is_regoffs_o", d_addr_is_regoffs_o, e_regoffs);
		check_except("d_except_o", d_except_o, e_except);
	endtask

	task automatic compare_idle();
		check_word("d_pc_o", d_pc_o, exp_pc);
		check_bit("d_starved_o", d_starved_o, 1'b1);
		check_except("d_except_o", d_except_o, EXCEPT_NONE);
		check_memop("d_memop_o", d_memop_o, MEMOP_NONE);
		check_bcond("d_branchcond_o", d_branchcond_o, BCOND_NEVER);
		check_reg("d_rd_o", d_rd_o, '0);
	endtask

	task automatic push_word(input word_t w, input logic err);
		int waited;
		waited = 0;
		while (!fetch_ready_o) begin
			next_cycle();
			waited++;
			if (waited > 20)
				abort_run("fetch_ready_o stayed low, the queue never drained");
		end
		fetch_vld_i   = 1'b1;
		fetch_instr_i = w;
		fetch_err_i   = err;
		next_cycle();
		fetch_vld_i = 1'b0;
		fetch_err_i = 1'b0;
	endtask

	// Push one word, check its decode, then check that it was consumed
	task automatic run_one(input word_t w, input logic err);
		push_word(w, err);
		#1;
		compare_decoded(w, err);
		next_cycle();
		exp_pc = exp_pc + 32'd4;
		#1;
		compare_idle();
		next_cycle();
	endtask

	// -------------------------------------------------------------------
	// Directed tests

	task automatic test_reset_state();
		#1;
		check_word("d_pc_o", d_pc_o, RESET_VECTOR);
		check_bit("fetch_ready_o", fetch_ready_o, 1'b1);
		compare_idle();
		next_cycle();
	endtask

	task automatic test_alu_ops();
		word_t r;
		rand_word(r);
		run_one(enc_i(r[31:20], r[19:15], 3'b000, r[11:7], OPC_OP_IMM), 1'b0);
		rand_word(r);
		run_one(enc_i(r[31:20], r[19:15], 3'b011, r[11:7], OPC_OP_IMM), 1'b0);
		rand_word(r);
		run_one(enc_i({7'b0100000, r[24:20]}, r[19:15], 3'b101, r[11:7], OPC_OP_IMM), 1'b0);
		rand_word(r);
		run_one(enc_r(7'b0000000, r[24:20], r[19:15], 3'b000, r[11:7]), 1'b0);
		rand_word(r);
		run_one(enc_r(7'b0100000, r[24:20], r[19:15], 3'b000, r[11:7]), 1'b0);
		rand_word(r);
		run_one(enc_u(r[31:12], r[11:7], OPC_LUI), 1'b0);
		rand_word(r);
		run_one(enc_u(r[31:12], r[11:7], OPC_AUIPC), 1'b0);
	endtask

	task automatic test_mem_and_flow();
		word_t      r;
		int         i;
		logic [2:0] load_f3 [5];
		logic [2:0] br_f3 [6];
		load_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
		br_f3   = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		for (i = 0; i < 5; i++) begin
			rand_word(r);
			run_one(enc_i(r[31:20], r[19:15], load_f3[i], r[11:7], OPC_LOAD), 1'b0);
		end
		for (i = 0; i < 3; i++) begin
			rand_word(r);
			run_one(enc_s(r[31:20], r[24:20], r[19:15], 3'(i)), 1'b0);
		end
		for (i = 0; i < 6; i++) begin
			rand_word(r);
			run_one(enc_b(r[12:0], r[24:20], r[19:15], br_f3[i]), 1'b0);
		end
		rand_word(r);
		run_one(enc_j(r[20:0], r[11:7]), 1'b0);
		rand_word(r);
		run_one(enc_i(r[31:20], r[19:15], 3'b000, r[11:7], OPC_JALR), 1'b0);
	endtask

	task automatic test_exceptions();
		word_t r;
		rand_word(r);
		// Major opcode 11111 is outside RV32I
		run_one({r[31:7], 7'b1111111}, 1'b0);
		rand_word(r);
		run_one(enc_r(7'b0000000, r[24:20], r[19:15], 3'b000, r[11:7]), 1'b1);
	endtask

	task automatic test_stream_and_stall();
		word_t w [4];
		word_t r;
		int    i;
		for (i = 0; i < 4; i++) begin
			rand_word(r);
			w[i] = enc_i(r[31:20], r[19:15], 3'b000, r[11:7], OPC_OP_IMM);
		end
		// One word pushed and one consumed in every cycle
		fetch_vld_i   = 1'b1;
		fetch_instr_i = w[0];
		next_cycle();
		for (i = 1; i < 4; i++) begin
			fetch_instr_i = w[i];
			#1;
			compare_decoded(w[i-1], 1'b0);
			check_bit("fetch_ready_o", fetch_ready_o, 1'b1);
			next_cycle();
			exp_pc = exp_pc + 32'd4;
		end
		fetch_vld_i = 1'b0;
		#1;
		compare_decoded(w[3], 1'b0);
		next_cycle();
		exp_pc = exp_pc + 32'd4;
		#1;
		compare_idle();
		next_cycle();

		// While execute stalls the queue fills and the head holds
		x_stall_i = 1'b1;
		for (i = 0; i < CIR_DEPTH; i++) begin
			check_bit("fetch_ready_o", fetch_ready_o, 1'b1);
			fetch_vld_i   = 1'b1;
			fetch_instr_i = w[i];
			next_cycle();
		end
		fetch_vld_i = 1'b0;
		#1;
		check_bit("fetch_ready_o", fetch_ready_o, 1'b0);
		compare_decoded(w[0], 1'b0);
		next_cycle();
		// Offered while full, so it is dropped
		fetch_vld_i   = 1'b1;
		fetch_instr_i = w[3];
		next_cycle();
		fetch_vld_i = 1'b0;
		#1;
		compare_decoded(w[0], 1'b0);
		next_cycle();
		x_stall_i = 1'b0;
		for (i = 0; i < CIR_DEPTH; i++) begin
			#1;
			compare_decoded(w[i], 1'b0);
			next_cycle();
			exp_pc = exp_pc + 32'd4;
		end
		#1;
		compare_idle();
		next_cycle();
	endtask

	task automatic test_jump();
		word_t r;
		word_t target;
		rand_word(r);
		target    = {r[31:2], 2'b00};
		x_stall_i = 1'b1;
		rand_word(r);
		push_word(enc_i(r[31:20], r[19:15], 3'b000, r[11:7], OPC_OP_IMM), 1'b0);
		// The push in the jump cycle is discarded by the flush
		fetch_vld_i   = 1'b1;
		fetch_instr_i = enc_u(r[31:12], r[11:7], OPC_LUI);
		jump_now_i    = 1'b1;
		jump_target_i = target;
		next_cycle();
		fetch_vld_i = 1'b0;
		jump_now_i  = 1'b0;
		x_stall_i   = 1'b0;
		exp_pc      = target;
		#1;
		compare_idle();
		check_bit("fetch_ready_o", fetch_ready_o, 1'b1);
		next_cycle();
		rand_word(r);
		run_one(enc_r(7'b0000000, r[24:20], r[19:15], 3'b110, r[11:7]), 1'b0);
	endtask

	// -------------------------------------------------------------------

	initial begin
		#(TIMEOUT);
		abort_run("Watchdog expired before the tests finished");
	end

	// A failed assertion in the bound checker ends the run at once
	always @(DUT.u_asserts.fail_count) begin
		if (DUT.u_asserts.fail_count != 0)
			abort_run("An assertion in the bound checker failed");
	end

	initial begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		fetch_vld_i   = 1'b0;
		fetch_instr_i = '0;
		fetch_err_i   = 1'b0;
		x_stall_i     = 1'b0;
		jump_now_i    = 1'b0;
		jump_target_i = '0;
		seed          = 32'h77f1_3dcb;
		exp_pc        = RESET_VECTOR;
		repeat (5) @(posedge clk);
		#0.5;
		rst_n = 1'b1;

		test_reset_state();
		test_alu_ops();
		test_mem_and_flow();
		test_exceptions();
		test_stream_and_stall();
		test_jump();

		if (DUT.u_asserts.fail_count != 0)
			abort_run("Assertion failures were reported during the run");
		else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

// ==== verification/rv_decode_asserts.sv ====
`timescale 1ns/1ps

module rv_decode_asserts (
	input logic                    clk,
	input logic                    rst_n,
	input logic                    d_starved_i,
	input logic                    head_err_i,
	input rv_decode_pkg::word_t    d_pc_i,
	input rv_decode_pkg::memop_e   d_memop_i,
	input rv_decode_pkg::bcond_e   d_branchcond_i,
	input rv_decode_pkg::except_e  d_except_i
);
	import rv_decode_pkg::*;

	// Number of failed assertions so far
	int fail_count = 0;

	// An empty slot must not start a memory access or a branch
	starved_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		d_starved_i |-> (d_memop_i == MEMOP_NONE && d_branchcond_i == BCOND_NEVER))
	else begin
		fail_count = fail_count + 1;
		$error("starved slot carries a memory operation or a branch");
	end

	pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		d_pc_i[1:0] == 2'b00)
	else begin
		fail_count = fail_count + 1;
		$error("d_pc_o is not word aligned");
	end

	fault_flagged: assert property (@(posedge clk) disable iff (!rst_n)
		(!d_starved_i && head_err_i) |-> d_except_i != EXCEPT_NONE)
	else begin
		fail_count = fail_count + 1;
		$error("bus error head decoded without an exception");
	end

endmodule

bind rv_decode_stage rv_decode_asserts u_asserts (
	.clk            (clk),
	.rst_n          (rst_n),
	.d_starved_i    (d_starved_o),
	.head_err_i     (cir_bus.head_err),
	.d_pc_i         (d_pc_o),
	.d_memop_i      (d_memop_o),
	.d_branchcond_i (d_branchcond_o),
	.d_except_i     (d_except_o)
);

// ==== logic/rv_decode_stage.sv ====
`timescale 1ns/1ps

module rv_decode_stage #(
	parameter rv_decode_pkg::word_t RESET_VECTOR = '0,
	parameter int                   CIR_DEPTH    = 2
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      fetch_vld_i,
	input  rv_decode_pkg::word_t      fetch_instr_i,
	input  logic                      fetch_err_i,
	output logic                      fetch_ready_o,
	input  logic                      x_stall_i,
	input  logic                      jump_now_i,
	input  rv_decode_pkg::word_t      jump_target_i,
	output rv_decode_pkg::word_t      d_pc_o,
	output logic                      d_starved_o,
	output rv_decode_pkg::except_e    d_except_o,
	output rv_decode_pkg::regaddr_t   d_rs1_o,
	output rv_decode_pkg::regaddr_t   d_rs2_o,
	output rv_decode_pkg::regaddr_t   d_rd_o,
	output rv_decode_pkg::word_t      d_imm_o,
	output rv_decode_pkg::word_t      d_addr_offs_o,
	output rv_decode_pkg::aluop_e     d_aluop_o,
	output rv_decode_pkg::alusrc_a_e  d_alusrc_a_o,
	output rv_decode_pkg::alusrc_b_e  d_alusrc_b_o,
	output rv_decode_pkg::memop_e     d_memop_o,
	output rv_decode_pkg::bcond_e     d_branchcond_o,
	output logic                      d_addr_is_regoffs_o
);

	cir_if cir_bus ();
	dec_if dec_bus ();

	// Jump flush from the controller into the queue
	logic flush;

	fetch_queue #(
		.CIR_DEPTH (CIR_DEPTH)
	) u_fetch_queue (
		.clk          (clk),
		.rst_n        (rst_n),
		.flush_i      (flush),
		.push_i       (fetch_vld_i),
		.push_instr_i (fetch_instr_i),
		.push_err_i   (fetch_err_i),
		.ready_o      (fetch_ready_o),
		.cir          (cir_bus.queue)
	);

	instr_decoder u_instr_decoder (
		.cir (cir_bus.decode),
		.dec (dec_bus.decoder)
	);

	decode_ctrl #(
		.RESET_VECTOR (RESET_VECTOR)
	) u_decode_ctrl (
		.clk                 (clk),
		.rst_n               (rst_n),
		.x_stall_i           (x_stall_i),
		.jump_now_i          (jump_now_i),
		.jump_target_i       (jump_target_i),
		.cir                 (cir_bus.decode),
		.dec                 (dec_bus.ctrl),
		.flush_o             (flush),
		.d_pc_o              (d_pc_o),
		.d_starved_o         (d_starved_o),
		.d_except_o          (d_except_o),
		.d_rs1_o             (d_rs1_o),
		.d_rs2_o             (d_rs2_o),
		.d_rd_o              (d_rd_o),
		.d_imm_o             (d_imm_o),
		.d_addr_offs_o       (d_addr_offs_o),
		.d_aluop_o           (d_aluop_o),
		.d_alusrc_a_o        (d_alusrc_a_o),
		.d_alusrc_b_o        (d_alusrc_b_o),
		.d_memop_o           (d_memop_o),
		.d_branchcond_o      (d_branchcond_o),
		.d_addr_is_regoffs_o (d_addr_is_regoffs_o)
	);

endmodule

// ==== logic/decode_ctrl.sv ====
`timescale 1ns/1ps

module decode_ctrl #(
	parameter rv_decode_pkg::word_t RESET_VECTOR = '0
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      x_stall_i,
	input  logic                      jump_now_i,
	input  rv_decode_pkg::word_t      jump_target_i,
	cir_if.decode                     cir,
	dec_if.ctrl                       dec,
	output logic                      flush_o,
	output rv_decode_pkg::word_t      d_pc_o,
	output logic                      d_starved_o,
	output rv_decode_pkg::except_e    d_except_o,
	output rv_decode_pkg::regaddr_t   d_rs1_o,
	output rv_decode_pkg::regaddr_t   d_rs2_o,
	output rv_decode_pkg::regaddr_t   d_rd_o,
	output rv_decode_pkg::word_t      d_imm_o,
	output rv_decode_pkg::word_t      d_addr_offs_o,
	output rv_decode_pkg::aluop_e     d_aluop_o,
	output rv_decode_pkg::alusrc_a_e  d_alusrc_a_o,
	output rv_decode_pkg::alusrc_b_e  d_alusrc_b_o,
	output rv_decode_pkg::memop_e     d_memop_o,
	output rv_decode_pkg::bcond_e     d_branchcond_o,
	output logic                      d_addr_is_regoffs_o
);
	import rv_decode_pkg::*;

	word_t pc_q;
	logic  starved;
	logic  bus_fault;
	logic  squash;

	assign starved   = !cir.head_vld;
	assign bus_fault = cir.head_vld && cir.head_err;
	assign squash    = starved || bus_fault || dec.illegal;

	// -------------------------------------------------------------------
	// Consume and PC

	assign cir.pop = cir.head_vld && !x_stall_i;
	assign flush_o = jump_now_i;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= RESET_VECTOR;
		end else if (jump_now_i) begin
			pc_q <= jump_target_i;
		end else if (cir.pop) begin
			pc_q <= pc_q + word_t'(4);
		end
	end

	assign d_pc_o      = pc_q;
	assign d_starved_o = starved;

	// -------------------------------------------------------------------
	// Outputs to execute

	assign d_imm_o             = dec.imm;
	assign d_addr_offs_o       = dec.addr_offs;
	assign d_aluop_o           = dec.aluop;
	assign d_alusrc_a_o        = dec.alusrc_a;
	assign d_alusrc_b_o        = dec.alusrc_b;
	assign d_addr_is_regoffs_o = dec.addr_is_regoffs;

	// No side effects reach execute from a squashed slot
	always_comb begin
		d_rs1_o        = squash ? '0 : dec.rs1;
		d_rs2_o        = squash ? '0 : dec.rs2;
		d_rd_o         = squash ? '0 : dec.rd;
		d_memop_o      = dec.memop;
		d_branchcond_o = dec.branchcond;
		if (squash) begin
			d_memop_o      = MEMOP_NONE;
			d_branchcond_o = BCOND_NEVER;
		end
		if (bus_fault)
			d_except_o = EXCEPT_INSTR_FAULT;
		else if (!starved && dec.illegal)
			d_except_o = EXCEPT_INSTR_ILLEGAL;
		else
			d_except_o = EXCEPT_NONE;
	end

endmodule

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
	cir_if.decode  cir,
	dec_if.decoder dec
);
	import rv_decode_pkg::*;

	localparam regaddr_t X0 = '0;

	word_t   instr;
	opcode_e opc;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t   imm_i;
	word_t   imm_s;
	word_t   imm_b;
	word_t   imm_u;
	word_t   imm_j;

	// Shared by register and immediate ALU operations
	function automatic aluop_e alu_op_of(input logic [2:0] f3, input logic alt);
		aluop_e op;
		case (f3)
			3'b000:  op = alt ? ALUOP_SUB : ALUOP_ADD;
			3'b001:  op = ALUOP_SLL;
			3'b010:  op = ALUOP_LT;
			3'b011:  op = ALUOP_LTU;
			3'b100:  op = ALUOP_XOR;
			3'b101:  op = alt ? ALUOP_SRA : ALUOP_SRL;
			3'b110:  op = ALUOP_OR;
			default: op = ALUOP_AND;
		endcase
		return op;
	endfunction

	assign instr  = cir.head_instr;
	assign opc    = opcode_e'(instr[6:2]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// -------------------------------------------------------------------
	// Immediate formats

	assign imm_i = {{21{instr[31]}}, instr[30:20]};
	assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'h000};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		case (opc)
			OPC_JAL:    dec.addr_offs = imm_j;
			OPC_BRANCH: dec.addr_offs = imm_b;
			OPC_STORE:  dec.addr_offs = imm_s;
			OPC_JALR:   dec.addr_offs = imm_i;
			OPC_LOAD:   dec.addr_offs = imm_i;
			default:    dec.addr_offs = '0;
		endcase
	end

	// -------------------------------------------------------------------
	// Execute controls

	always_comb begin
		dec.rs1             = instr[19:15];
		dec.rs2             = instr[24:20];
		dec.rd              = instr[11:7];
		dec.imm             = imm_i;
		dec.aluop           = ALUOP_ADD;
		dec.alusrc_a        = ALUSRCA_RS1;
		dec.alusrc_b        = ALUSRCB_RS2;
		dec.memop           = MEMOP_NONE;
		dec.branchcond      = BCOND_NEVER;
		dec.addr_is_regoffs = 1'b0;
		// Anything outside the 32-bit space is illegal, no compressed forms
		dec.illegal         = instr[1:0] != 2'b11;

		case (opc)
			OPC_OP_IMM: begin
				dec.rs2      = X0;
				dec.alusrc_b = ALUSRCB_IMM;
				dec.aluop    = alu_op_of(funct3, funct3 == 3'b101 && instr[30]);
				if (funct3 == 3'b001 && funct7 != 7'b0000000)
					dec.illegal = 1'b1;
				if (funct3 == 3'b101 && {funct7[6], funct7[4:0]} != 6'b0)
					dec.illegal = 1'b1;
			end
			OPC_OP: begin
				dec.aluop = alu_op_of(funct3, instr[30]);
				if ({funct7[6], funct7[4:0]} != 6'b0)
					dec.illegal = 1'b1;
				if (funct7[5] && funct3 != 3'b000 && funct3 != 3'b101)
					dec.illegal = 1'b1;
			end
			OPC_LUI: begin
				dec.rs1      = X0;
				dec.rs2      = X0;
				dec.imm      = imm_u;
				dec.aluop    = ALUOP_RS2;
				dec.alusrc_b = ALUSRCB_IMM;
			end
			OPC_AUIPC: begin
				dec.rs1      = X0;
				dec.rs2      = X0;
				dec.imm      = imm_u;
				dec.alusrc_a = ALUSRCA_PC;
				dec.alusrc_b = ALUSRCB_IMM;
			end
			OPC_LOAD: begin
				dec.rs2             = X0;
				dec.addr_is_regoffs = 1'b1;
				case (funct3)
					3'b000:  dec.memop = MEMOP_LB;
					3'b001:  dec.memop = MEMOP_LH;
					3'b010:  dec.memop = MEMOP_LW;
					3'b100:  dec.memop = MEMOP_LBU;
					3'b101:  dec.memop = MEMOP_LHU;
					default: dec.illegal = 1'b1;
				endcase
			end
			OPC_STORE: begin
				dec.rd              = X0;
				dec.aluop           = ALUOP_RS2;
				dec.addr_is_regoffs = 1'b1;
				case (funct3)
					3'b000:  dec.memop = MEMOP_SB;
					3'b001:  dec.memop = MEMOP_SH;
					3'b010:  dec.memop = MEMOP_SW;
					default: dec.illegal = 1'b1;
				endcase
			end
			OPC_BRANCH: begin
				dec.rd = X0;
				// BEQ/BNE subtract, the rest compare and test the flag
				if (!funct3[2])
					dec.aluop = ALUOP_SUB;
				else if (funct3[1])
					dec.aluop = ALUOP_LTU;
				else
					dec.aluop = ALUOP_LT;
				if (funct3[0] ^ funct3[2])
					dec.branchcond = BCOND_NZERO;
				else
					dec.branchcond = BCOND_ZERO;
				if (funct3[2:1] == 2'b01)
					dec.illegal = 1'b1;
			end
			OPC_JAL: begin
				dec.rs1        = X0;
				dec.rs2        = X0;
				dec.imm        = 32'h0000_0004;
				dec.alusrc_a   = ALUSRCA_PC;
				dec.alusrc_b   = ALUSRCB_IMM;
				dec.branchcond = BCOND_ALWAYS;
			end
			OPC_JALR: begin
				dec.rs2             = X0;
				dec.imm             = 32'h0000_0004;
				dec.alusrc_a        = ALUSRCA_PC;
				dec.alusrc_b        = ALUSRCB_IMM;
				dec.branchcond      = BCOND_ALWAYS;
				dec.addr_is_regoffs = 1'b1;
				if (funct3 != 3'b000)
					dec.illegal = 1'b1;
			end
			OPC_MISC_MEM: begin
				// FENCE retires as a no-op, FENCE.I is not supported
				dec.rs2 = X0;
				if (funct3 != 3'b000)
					dec.illegal = 1'b1;
			end
			default: begin
				dec.illegal = 1'b1;
			end
		endcase
	end

endmodule

// ==== logic/fetch_queue.sv ====
`timescale 1ns/1ps

module fetch_queue #(
	parameter int CIR_DEPTH = 2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 flush_i,
	input  logic                 push_i,
	input  rv_decode_pkg::word_t push_instr_i,
	input  logic                 push_err_i,
	output logic                 ready_o,
	cir_if.queue                 cir
);
	import rv_decode_pkg::*;

	localparam int PTR_W = $clog2(CIR_DEPTH);

	word_t            instr_mem [CIR_DEPTH];
	logic             err_mem   [CIR_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             full;
	logic             push_ok;
	logic             pop_ok;

	assign full    = count == (PTR_W+1)'(CIR_DEPTH);
	assign ready_o = !full;

	// A flush drops anything arriving in the same cycle
	assign push_ok = push_i && !full && !flush_i;
	assign pop_ok  = cir.pop && !flush_i;

	always_ff @(posedge clk) begin
		if (push_ok) begin
			instr_mem[wr_ptr] <= push_instr_i;
			err_mem[wr_ptr]   <= push_err_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Pointers wrap naturally, depth is a power of two
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign cir.head_vld   = count != '0;
	assign cir.head_instr = instr_mem[rd_ptr];
	assign cir.head_err   = err_mem[rd_ptr];

endmodule

// ==== logic/dec_if.sv ====
`timescale 1ns/1ps

interface dec_if;
	import rv_decode_pkg::*;

	regaddr_t  rs1;
	regaddr_t  rs2;
	regaddr_t  rd;
	word_t     imm;
	word_t     addr_offs;
	aluop_e    aluop;
	alusrc_a_e alusrc_a;
	alusrc_b_e alusrc_b;
	memop_e    memop;
	bcond_e    branchcond;
	logic      addr_is_regoffs;
	logic      illegal;

	modport decoder (
		output rs1, rs2, rd, imm, addr_offs,
		output aluop, alusrc_a, alusrc_b, memop, branchcond,
		output addr_is_regoffs, illegal
	);

	// Raw fields, squashing happens in the controller
	modport ctrl (
		input rs1, rs2, rd, imm, addr_offs,
		input aluop, alusrc_a, alusrc_b, memop, branchcond,
		input addr_is_regoffs, illegal
	);
endinterface

// ==== logic/cir_if.sv ====
`timescale 1ns/1ps

interface cir_if;
	import rv_decode_pkg::*;

	// Head of the fetch queue
	logic  head_vld;
	word_t head_instr;
	logic  head_err;

	// Consume strobe back to the queue
	logic  pop;

	modport queue (
		output head_vld, head_instr, head_err,
		input  pop
	);

	modport decode (
		input  head_vld, head_instr, head_err,
		output pop
	);
endinterface

// ==== logic/rv_decode_pkg.sv ====
package rv_decode_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0]      regaddr_t;

	// Major opcode, instruction bits 6 to 2
	typedef enum logic [4:0] {
		OPC_LOAD     = 5'b00000,
		OPC_MISC_MEM = 5'b00011,
		OPC_OP_IMM   = 5'b00100,
		OPC_AUIPC    = 5'b00101,
		OPC_STORE    = 5'b01000,
		OPC_OP       = 5'b01100,
		OPC_LUI      = 5'b01101,
		OPC_BRANCH   = 5'b11000,
		OPC_JALR     = 5'b11001,
		OPC_JAL      = 5'b11011
	} opcode_e;

	typedef enum logic [3:0] {
		ALUOP_ADD,
		ALUOP_SUB,
		ALUOP_SLL,
		ALUOP_LT,
		ALUOP_LTU,
		ALUOP_XOR,
		ALUOP_SRL,
		ALUOP_SRA,
		ALUOP_OR,
		ALUOP_AND,
		// Pass operand B straight through
		ALUOP_RS2
	} aluop_e;

	typedef enum logic {ALUSRCA_RS1, ALUSRCA_PC} alusrc_a_e;
	typedef enum logic {ALUSRCB_RS2, ALUSRCB_IMM} alusrc_b_e;

	typedef enum logic [3:0] {
		MEMOP_NONE,
		MEMOP_LB,
		MEMOP_LH,
		MEMOP_LW,
		MEMOP_LBU,
		MEMOP_LHU,
		MEMOP_SB,
		MEMOP_SH,
		MEMOP_SW
	} memop_e;

	// Condition is tested against the ALU result
	typedef enum logic [1:0] {BCOND_NEVER, BCOND_ZERO, BCOND_NZERO, BCOND_ALWAYS} bcond_e;

	typedef enum logic [1:0] {EXCEPT_NONE, EXCEPT_INSTR_ILLEGAL, EXCEPT_INSTR_FAULT} except_e;

endpackage
